// File: logic/tcp_conn_fsm.sv
`timescale 1ns/1ps

module tcp_conn_fsm import tcp_pkg::*; #(
  parameter win_t WINDOW_SIZE = 1000
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   tmr_fire,
  input  logic   connect,
  input  logic   listen,
  input  port_t  loc_port,
  input  port_t  rem_port_req,
  input  seq_t   isn,
  input  logic   send,
  input  len_t   send_len,
  output logic   sent,
  input  logic   syn_rec,
  input  logic   syn_ack_rec,
  input  logic   ack_rec,
  input  logic   fin_rec,
  input  logic   rst_rec,
  input  logic   seg_rec,
  input  seq_t   rx_seq,
  input  seq_t   rx_ack_num,
  input  len_t   rx_pld_len,
  output port_t  rem_port,
  output logic   tx_rdy,
  input  logic   tx_ack,
  input  logic   tx_done,
  output flags_t tx_flags,
  output seq_t   tx_seq,
  output seq_t   tx_ack_num,
  output port_t  tx_src_port,
  output port_t  tx_dst_port,
  output win_t   tx_win,
  output len_t   tx_pld_len,
  output logic   tmr_en,
  output logic   connected
);

  conn_state_t state;
  close_t      close;
  close_t      close_now;  // latched reason or a new one this cycle
  tx_kind_t    tx_kind;
  logic        server;     // opened by listen
  logic        user_up;
  logic        ack_owed;
  logic        tx_pend;    // header handed out, tx_done not yet seen

  // control block
  seq_t loc_seq;
  seq_t loc_ack;
  seq_t rem_seq;  // next expected peer seq
  seq_t rem_ack;

  logic   hdr_load;
  flags_t hdr_flags;
  len_t   hdr_len;

  logic syn_ack_ok;
  logic hs_ack_ok;
  logic fin_acked;
  seq_t fin_ack_num;

  assign user_up     = server ? listen : connect;
  assign fin_ack_num = loc_seq + 1;  // our fin takes one seq

  assign syn_ack_ok = syn_ack_rec && (rx_ack_num == loc_seq + 1);
  assign hs_ack_ok  = ack_rec && (rx_seq == rem_seq);
  assign fin_acked  = (rem_ack == fin_ack_num) || (ack_rec && rx_ack_num == fin_ack_num);

  // opening and closing are bounded by the timer
  assign tmr_en = !(state inside {closed_s, listen_s, established_idle_s, established_tx_s});

  always_comb begin
    close_now = close;
    if (close == close_none) begin
      if (!user_up) close_now = close_active;
      else if (fin_rec) close_now = close_passive;
      else if (rst_rec) close_now = close_reset;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // header select, loaded only once the previous segment has left
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hdr_load  = 1'b0;
    hdr_flags = '0;
    hdr_len   = '0;
    if (!tx_pend) begin
      case (state)
        send_syn_s : begin
          hdr_load  = 1'b1;
          hdr_flags = FLAG_SYN;
        end
        send_syn_ack_s : begin
          hdr_load  = 1'b1;
          hdr_flags = FLAG_SYN | FLAG_ACK;
        end
        send_ack_s : begin
          hdr_load  = 1'b1;
          hdr_flags = FLAG_ACK;
        end
        send_fin_s, send_last_ack_s : begin
          hdr_load  = 1'b1;
          hdr_flags = FLAG_FIN | FLAG_ACK;
        end
        send_rst_s : begin
          hdr_load  = 1'b1;
          hdr_flags = FLAG_RST | FLAG_ACK;
        end
        established_idle_s : begin
          if (close_now == close_none) begin
            if (send) begin  // payload first
              hdr_load  = 1'b1;
              hdr_flags = FLAG_PSH | FLAG_ACK;
              hdr_len   = send_len;
            end else if (ack_owed) begin
              hdr_load  = 1'b1;
              hdr_flags = FLAG_ACK;
            end
          end
        end
        default : ;
      endcase
    end
  end

  // header registers, all fields taken in one cycle
  always_ff @(posedge clk) begin
    if (hdr_load) begin
      tx_flags    <= hdr_flags;
      tx_seq      <= loc_seq;
      tx_ack_num  <= loc_ack;
      tx_src_port <= loc_port;
      tx_dst_port <= rem_port;
      tx_win      <= WINDOW_SIZE;
      tx_pld_len  <= hdr_len;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control block
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ack_rec) rem_ack <= rx_ack_num;
    case (state)
      closed_s : begin  // fresh block for the next open
        rem_port <= rem_port_req;
        loc_seq  <= isn;
        loc_ack  <= '0;
        rem_seq  <= '0;
        rem_ack  <= '0;
      end
      listen_s : begin
        if (syn_rec) begin
          loc_ack <= rx_seq + 1;
          rem_seq <= rx_seq + 1;
        end
      end
      syn_sent_s : begin
        if (syn_ack_ok) begin
          loc_seq <= loc_seq + 1;
          loc_ack <= rx_seq + 1;
          rem_seq <= rx_seq + 1;
        end
      end
      syn_ack_sent_s : begin
        if (hs_ack_ok) loc_seq <= loc_seq + 1;
      end
      established_idle_s, established_tx_s : begin
        if (seg_rec) begin
          rem_seq <= rx_seq + seq_t'(rx_pld_len);
          loc_ack <= loc_ack + seq_t'(rx_pld_len) + seq_t'(fin_rec); // fin counts one
        end
        if (state == established_tx_s && tx_done) begin
          loc_seq <= loc_seq + seq_t'(tx_pld_len);  // zero for a plain ack
        end
      end
      fin_sent_s : begin
        if (fin_rec && fin_acked) loc_ack <= loc_ack + 1;
      end
      default : ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || tmr_fire) begin
      state     <= closed_s;
      close     <= close_none;
      tx_kind   <= tx_idle;
      server    <= 1'b0;
      ack_owed  <= 1'b0;
      tx_rdy    <= 1'b0;
      tx_pend   <= 1'b0;
      sent      <= 1'b0;
      connected <= 1'b0;
    end else begin
      sent <= 1'b0;
      if (tx_ack) tx_rdy <= 1'b0;  // header taken
      if (tx_done) tx_pend <= 1'b0;
      if (hdr_load) begin
        tx_rdy  <= 1'b1;
        tx_pend <= 1'b1;
      end
      if (hdr_load && state == established_idle_s && !send) ack_owed <= 1'b0;
      if (seg_rec && rx_pld_len != '0) ack_owed <= 1'b1;  // new data wins
      case (state)
        closed_s : begin
          close    <= close_none;
          tx_kind  <= tx_idle;
          ack_owed <= 1'b0;
          if (listen) begin
            server <= 1'b1;
            state  <= listen_s;
          end else if (connect) begin
            server <= 1'b0;
            state  <= send_syn_s;
          end
        end
        listen_s : begin
          if (!listen) state <= closed_s;
          else if (syn_rec) state <= send_syn_ack_s;
        end
        send_syn_s : if (hdr_load) state <= syn_sent_s;
        syn_sent_s : if (syn_ack_ok) state <= send_ack_s;
        send_ack_s : if (hdr_load) state <= ack_sent_s;
        ack_sent_s : begin
          if (tx_done) begin
            case (close)
              close_none : begin  // last step of active open
                state     <= established_idle_s;
                connected <= 1'b1;
              end
              close_passive : state <= send_last_ack_s;
              default : begin
                state     <= closed_s;
                connected <= 1'b0;
              end
            endcase
          end
        end
        send_syn_ack_s : if (hdr_load) state <= syn_ack_sent_s;
        syn_ack_sent_s : begin
          if (hs_ack_ok) begin
            state     <= established_idle_s;
            connected <= 1'b1;
          end
        end
        established_idle_s : begin
          close <= close_now;
          if (close_now != close_none) begin
            if (!tx_pend) begin
              case (close_now)
                close_active  : state <= send_fin_s;
                close_passive : state <= send_ack_s;
                default       : state <= send_rst_s;
              endcase
            end
          end else if (hdr_load) begin
            state   <= established_tx_s;
            tx_kind <= send ? tx_payload : tx_forced_ack;
          end
        end
        established_tx_s : begin
          close <= close_now;  // acted on back in idle
          if (tx_kind == tx_idle) begin
            state <= established_idle_s;  // app has seen sent by now
          end else if (tx_done) begin
            sent    <= (tx_kind == tx_payload);
            tx_kind <= tx_idle;
          end
        end
        send_fin_s : if (hdr_load) state <= fin_sent_s;
        fin_sent_s : begin
          if (fin_rec && fin_acked) state <= send_ack_s;  // fin_wait 1 and 2
        end
        send_last_ack_s : if (hdr_load) state <= last_ack_sent_s;
        last_ack_sent_s : begin
          if (ack_rec) begin
            state     <= closed_s;
            connected <= 1'b0;
          end
        end
        send_rst_s : begin
          if (tx_done) begin  // entered idle, so this is our rst
            state     <= closed_s;
            connected <= 1'b0;
          end
        end
        default : state <= closed_s;
      endcase
    end
  end

endmodule

// File: logic/tcp_conn_timer.sv
`timescale 1ns/1ps

module tcp_conn_timer #(
  parameter int TIMEOUT_TICKS = 1000
) (
  input  logic clk,
  input  logic rst,
  input  logic tmr_en,
  output logic tmr_fire
);

  localparam int CNT_W = $clog2(TIMEOUT_TICKS + 1);

  logic [CNT_W-1:0] cnt;

  // counts consecutive enabled cycles, any gap starts over
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt      <= '0;
      tmr_fire <= 1'b0;
    end else if (!tmr_en) begin
      cnt      <= '0;
      tmr_fire <= 1'b0;
    end else if (cnt == CNT_W'(TIMEOUT_TICKS - 1)) begin
      cnt      <= '0;
      tmr_fire <= 1'b1;  // single pulse, fsm drops tmr_en after it
    end else begin
      cnt      <= cnt + 1'b1;
      tmr_fire <= 1'b0;
    end
  end

endmodule

// File: logic/tcp_engine.sv
`timescale 1ns/1ps

module tcp_engine import tcp_pkg::*; #(
  parameter int   TIMEOUT_TICKS = 1000,
  parameter win_t WINDOW_SIZE   = 1000
) (
  input  logic   clk,
  input  logic   rst,
  // application
  input  logic   connect,
  input  logic   listen,
  input  port_t  loc_port,
  input  port_t  rem_port_req,
  input  seq_t   isn,
  input  logic   send,
  input  len_t   send_len,
  output logic   sent,
  output logic   connected,
  // received segment header
  input  logic   rx_val,
  input  port_t  rx_src_port,
  input  port_t  rx_dst_port,
  input  flags_t rx_flags,
  input  seq_t   rx_seq,
  input  seq_t   rx_ack_num,
  input  len_t   rx_pld_len,
  // transmit header
  output logic   tx_rdy,
  input  logic   tx_ack,
  input  logic   tx_done,
  output flags_t tx_flags,
  output seq_t   tx_seq,
  output seq_t   tx_ack_num,
  output port_t  tx_src_port,
  output port_t  tx_dst_port,
  output win_t   tx_win,
  output len_t   tx_pld_len
);

  port_t rem_port;
  logic  syn_rec;
  logic  syn_ack_rec;
  logic  ack_rec;
  logic  fin_rec;
  logic  rst_rec;
  logic  seg_rec;
  logic  tmr_en;
  logic  tmr_fire;

  tcp_rx_filter rx_filter_inst (
    .rx_val      (rx_val),
    .rx_src_port (rx_src_port),
    .rx_dst_port (rx_dst_port),
    .rx_flags    (rx_flags),
    .loc_port    (loc_port),
    .rem_port    (rem_port),
    .syn_rec     (syn_rec),
    .syn_ack_rec (syn_ack_rec),
    .ack_rec     (ack_rec),
    .fin_rec     (fin_rec),
    .rst_rec     (rst_rec),
    .seg_rec     (seg_rec)
  );

  // bounds open and close phases
  tcp_conn_timer #(
    .TIMEOUT_TICKS (TIMEOUT_TICKS)
  ) conn_timer_inst (
    .clk      (clk),
    .rst      (rst),
    .tmr_en   (tmr_en),
    .tmr_fire (tmr_fire)
  );

  tcp_conn_fsm #(
    .WINDOW_SIZE (WINDOW_SIZE)
  ) conn_fsm_inst (
    .clk          (clk),
    .rst          (rst),
    .tmr_fire     (tmr_fire),
    .connect      (connect),
    .listen       (listen),
    .loc_port     (loc_port),
    .rem_port_req (rem_port_req),
    .isn          (isn),
    .send         (send),
    .send_len     (send_len),
    .sent         (sent),
    .syn_rec      (syn_rec),
    .syn_ack_rec  (syn_ack_rec),
    .ack_rec      (ack_rec),
    .fin_rec      (fin_rec),
    .rst_rec      (rst_rec),
    .seg_rec      (seg_rec),
    .rx_seq       (rx_seq),
    .rx_ack_num   (rx_ack_num),
    .rx_pld_len   (rx_pld_len),
    .rem_port     (rem_port),
    .tx_rdy       (tx_rdy),
    .tx_ack       (tx_ack),
    .tx_done      (tx_done),
    .tx_flags     (tx_flags),
    .tx_seq       (tx_seq),
    .tx_ack_num   (tx_ack_num),
    .tx_src_port  (tx_src_port),
    .tx_dst_port  (tx_dst_port),
    .tx_win       (tx_win),
    .tx_pld_len   (tx_pld_len),
    .tmr_en       (tmr_en),
    .connected    (connected)
  );

endmodule

// File: logic/tcp_pkg.sv
package tcp_pkg;

  //////////////////////////////////////////////////////////////////////
  // header field widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [15:0] port_t;  // tcp port number
  typedef logic [31:0] seq_t;   // seq / ack number
  typedef logic [15:0] len_t;   // payload bytes
  typedef logic [15:0] win_t;   // advertised window
  typedef logic [7:0]  flags_t;

  // standard flag bit positions
  localparam flags_t FLAG_FIN = 8'h01;
  localparam flags_t FLAG_SYN = 8'h02;
  localparam flags_t FLAG_RST = 8'h04;
  localparam flags_t FLAG_PSH = 8'h08;
  localparam flags_t FLAG_ACK = 8'h10;

  //////////////////////////////////////////////////////////////////////
  // state machine encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    closed_s,
    listen_s,
    send_syn_s,          // active open
    syn_sent_s,
    send_ack_s,          // shared by open and close
    ack_sent_s,
    send_syn_ack_s,      // passive open
    syn_ack_sent_s,
    established_idle_s,
    established_tx_s,
    send_fin_s,          // active close
    fin_sent_s,
    send_last_ack_s,     // passive close, our fin
    last_ack_sent_s,
    send_rst_s
  } conn_state_t;

  typedef enum logic [1:0] {
    close_none,
    close_active,
    close_passive,
    close_reset
  } close_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_payload,
    tx_forced_ack
  } tx_kind_t;

endpackage

// File: logic/tcp_rx_filter.sv
`timescale 1ns/1ps

module tcp_rx_filter import tcp_pkg::*; (
  input  logic   rx_val,
  input  port_t  rx_src_port,
  input  port_t  rx_dst_port,
  input  flags_t rx_flags,
  input  port_t  loc_port,
  input  port_t  rem_port,
  output logic   syn_rec,
  output logic   syn_ack_rec,
  output logic   ack_rec,
  output logic   fin_rec,
  output logic   rst_rec,
  output logic   seg_rec
);

  logic loc_match;   // addressed to our port
  logic conn_match;  // both ports of this connection
  logic has_syn;
  logic has_ack;
  logic has_fin;
  logic has_rst;

  assign loc_match  = rx_val && (rx_dst_port == loc_port);
  assign conn_match = loc_match && (rx_src_port == rem_port);

  // flag decode
  assign has_syn = |(rx_flags & FLAG_SYN);
  assign has_ack = |(rx_flags & FLAG_ACK);
  assign has_fin = |(rx_flags & FLAG_FIN);
  assign has_rst = |(rx_flags & FLAG_RST);

  //////////////////////////////////////////////////////////////////////
  // connection requests only need the local port

  assign syn_rec     = loc_match && (rx_flags == FLAG_SYN); // bare syn
  assign syn_ack_rec = loc_match && has_syn && has_ack;

  //////////////////////////////////////////////////////////////////////
  // everything else must belong to the open connection

  assign ack_rec = conn_match && has_ack;  // seq checked by the fsm
  assign fin_rec = conn_match && has_fin;
  assign rst_rec = conn_match && has_rst;
  assign seg_rec = conn_match;

endmodule

// File: sim/tcp_engine_checker.sv
`timescale 1ns/1ps

module tcp_engine_checker import tcp_pkg::*; (
  input logic   clk,
  input logic   rst,
  input logic   tx_rdy,
  input logic   tx_ack,
  input flags_t tx_flags,
  input seq_t   tx_seq,
  input seq_t   tx_ack_num,
  input port_t  tx_src_port,
  input port_t  tx_dst_port,
  input win_t   tx_win,
  input len_t   tx_pld_len,
  input logic   connected
);

  // header held until the peer takes it
  hdr_stable: assert property (@(posedge clk) disable iff (rst)
    tx_rdy && !tx_ack |=> tx_rdy && $stable({tx_flags, tx_seq, tx_ack_num, tx_src_port,
                                             tx_dst_port, tx_win, tx_pld_len}))
    else $error("transmit header changed before tx_ack");

  rdy_drop: assert property (@(posedge clk) disable iff (rst)
    tx_rdy && tx_ack |=> !tx_rdy)
    else $error("tx_rdy still high after tx_ack");

  reset_state: assert property (@(posedge clk) rst |=> !connected && !tx_rdy)
    else $error("connected or tx_rdy high after reset");

endmodule

bind tcp_engine tcp_engine_checker checker_inst (
  .clk         (clk),
  .rst         (rst),
  .tx_rdy      (tx_rdy),
  .tx_ack      (tx_ack),
  .tx_flags    (tx_flags),
  .tx_seq      (tx_seq),
  .tx_ack_num  (tx_ack_num),
  .tx_src_port (tx_src_port),
  .tx_dst_port (tx_dst_port),
  .tx_win      (tx_win),
  .tx_pld_len  (tx_pld_len),
  .connected   (connected)
);

// File: sim/tcp_engine_tb.sv
`timescale 1ns/1ps

module tcp_engine_tb import tcp_pkg::*; ;

  localparam int    LIMIT = 6 * 600;  // six tests of 600 cycles
  localparam port_t LOC   = 16'h1234;
  localparam port_t REM   = 16'h5678;
  localparam win_t  WIN   = 16'd4096;

  localparam int K_SYN     = 0;
  localparam int K_SYN_ACK = 1;
  localparam int K_ACK     = 2;
  localparam int K_PSH     = 3;
  localparam int K_FIN     = 4;
  localparam int K_RST     = 5;

  logic   clk          = 0;
  logic   rst          = 1;
  logic   connect      = 0;
  logic   listen       = 0;
  port_t  loc_port     = LOC;
  port_t  rem_port_req = REM;
  seq_t   isn          = '0;
  logic   send         = 0;
  len_t   send_len     = '0;
  logic   sent;
  logic   connected;
  logic   rx_val       = 0;
  port_t  rx_src_port  = '0;
  port_t  rx_dst_port  = '0;
  flags_t rx_flags     = '0;
  seq_t   rx_seq       = '0;
  seq_t   rx_ack_num   = '0;
  len_t   rx_pld_len   = '0;
  logic   tx_rdy;
  logic   tx_ack       = 0;
  logic   tx_done      = 0;
  flags_t tx_flags;
  seq_t   tx_seq;
  seq_t   tx_ack_num;
  port_t  tx_src_port;
  port_t  tx_dst_port;
  win_t   tx_win;
  len_t   tx_pld_len;

  logic [87:0] exp_q[$];  // {flags, seq, ack, len}
  logic [87:0] exp_h;
  int          exp_cnt  = 0;
  int          done_cnt = 0;
  int          errors   = 0;
  int          base     = 0;
  int          cycles   = 0;
  int          tests    = 0;
  string       cur_test = "reset";
  logic [7:0]  lfsr_s   = 8'd8;
  seq_t        m_seq;  // model control block
  seq_t        m_ack;
  seq_t        m_rem;

  tcp_engine #(.TIMEOUT_TICKS(200), .WINDOW_SIZE(WIN)) UUT (.*);

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // reference model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [87:0] expected_segment(input int kind, input seq_t s,
                                                   input seq_t a, input len_t l);
    flags_t f;
    f = FLAG_ACK;  // every segment but the first syn acks
    case (kind)
      K_SYN     : f = FLAG_SYN;
      K_SYN_ACK : f = FLAG_SYN | FLAG_ACK;
      K_PSH     : f = FLAG_PSH | FLAG_ACK;
      K_FIN     : f = FLAG_FIN | FLAG_ACK;
      K_RST     : f = FLAG_RST | FLAG_ACK;
      default   : f = FLAG_ACK;
    endcase
    if (kind == K_SYN) a = '0;
    if (kind != K_PSH) l = '0;  // only payload carries length
    return {f, s, a, l};
  endfunction

  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic expect_seg(input int kind, input seq_t s, input seq_t a, input len_t l);
    exp_q.push_back(expected_segment(kind, s, a, l));
    exp_cnt++;
  endtask

  task automatic wait_idle();
    while (done_cnt < exp_cnt) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic wait_conn(input logic level);
    while (connected !== level) @(posedge clk);
  endtask

  // one received header from the peer
  task automatic peer_seg(input flags_t f, input seq_t s, input seq_t a, input len_t l);
    @(posedge clk);
    rx_val <= 1'b1;
    rx_src_port <= REM;
    rx_dst_port <= LOC;
    rx_flags <= f;
    rx_seq <= s;
    rx_ack_num <= a;
    rx_pld_len <= l;
    @(posedge clk);
    rx_val <= 1'b0;
  endtask

  task automatic end_test();
    tests++;
    $display("test %0d %s: %0d errors", tests, cur_test, errors - base);
    base = errors;
  endtask

  task automatic active_open(input seq_t s0, input seq_t p);
    cur_test = "active_open";
    m_seq = s0;
    m_ack = '0;
    expect_seg(K_SYN, m_seq, m_ack, 0);
    @(posedge clk);
    isn <= s0;
    connect <= 1'b1;
    wait_idle();
    m_seq = s0 + 1;
    m_ack = p + 1;
    m_rem = p + 1;
    expect_seg(K_ACK, m_seq, m_ack, 0);
    peer_seg(FLAG_SYN | FLAG_ACK, p, s0 + 1, 0);
    wait_idle();
    wait_conn(1'b1);
  endtask

  task automatic send_payload(input len_t l);
    expect_seg(K_PSH, m_seq, m_ack, l);
    send <= 1'b1;
    send_len <= l;
    @(posedge clk);
    while (!sent) @(posedge clk);
    send <= 1'b0;
    m_seq = m_seq + l;
    repeat (3) @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // remote peer and compare
  //////////////////////////////////////////////////////////////////////

  initial begin : peer
    logic [1:0] d;
    forever begin
      @(posedge clk);
      if (tx_rdy && !rst) begin
        d = '0;
        repeat (2) begin
          lfsr_s = lfsr_next(lfsr_s);
          d = {d[0], lfsr_s[0]};
        end
        repeat (d) @(posedge clk);
        tx_ack <= 1'b1;
        @(posedge clk);
        tx_ack <= 1'b0;
        repeat (2) @(posedge clk);
        tx_done <= 1'b1;
        @(posedge clk);
        tx_done <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (tx_done) done_cnt <= done_cnt + 1;
    if (!rst && tx_rdy && tx_ack) begin
      if (exp_q.size() == 0) begin
        $display("unexpected segment from the DUT in test %s", cur_test);
        errors++;
      end else begin
        exp_h = exp_q.pop_front();
        assert (tx_flags == exp_h[87:80]) else begin
          $display("CHECK FAILED %s flags expected %h actual %h",
                   cur_test, exp_h[87:80], tx_flags);
          errors++;
        end
        assert (tx_seq == exp_h[79:48]) else begin
          $display("CHECK FAILED %s seq expected %h actual %h",
                   cur_test, exp_h[79:48], tx_seq);
          errors++;
        end
        assert (tx_ack_num == exp_h[47:16]) else begin
          $display("CHECK FAILED %s ack expected %h actual %h",
                   cur_test, exp_h[47:16], tx_ack_num);
          errors++;
        end
        assert (tx_pld_len == exp_h[15:0]) else begin
          $display("CHECK FAILED %s len expected %h actual %h",
                   cur_test, exp_h[15:0], tx_pld_len);
          errors++;
        end
        assert (tx_src_port == LOC && tx_dst_port == REM) else begin
          $display("CHECK FAILED %s ports expected %h actual %h", cur_test,
                   {LOC, REM}, {tx_src_port, tx_dst_port});
          errors++;
        end
        assert (tx_win == WIN) else begin
          $display("CHECK FAILED %s win expected %h actual %h",
                   cur_test, WIN, tx_win);
          errors++;
        end
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("run stopped at the cycle limit in test %s", cur_test);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    active_open(32'h1000_0000, 32'hA000_0000);
    end_test();

    cur_test = "payload";
    send_payload(100);
    send_payload(37);
    end_test();

    cur_test = "forced_ack";
    expect_seg(K_ACK, m_seq, m_ack + 50, 0);
    peer_seg(FLAG_PSH | FLAG_ACK, m_rem, m_seq, 50);
    m_ack = m_ack + 50;
    m_rem = m_rem + 50;
    wait_idle();
    end_test();

    cur_test = "active_close";
    expect_seg(K_FIN, m_seq, m_ack, 0);
    connect <= 1'b0;
    wait_idle();
    expect_seg(K_ACK, m_seq, m_ack + 1, 0);  // peer fin takes one
    peer_seg(FLAG_ACK, m_rem, m_seq + 1, 0);
    peer_seg(FLAG_FIN | FLAG_ACK, m_rem, m_seq + 1, 0);
    wait_idle();
    wait_conn(1'b0);
    end_test();

    cur_test = "passive_open_close";
    isn <= 32'h2000_0000;
    listen <= 1'b1;
    repeat (3) @(posedge clk);
    m_seq = 32'h2000_0000;
    m_ack = 32'h3000_0001;
    m_rem = 32'h3000_0001;
    expect_seg(K_SYN_ACK, m_seq, m_ack, 0);
    peer_seg(FLAG_SYN, 32'h3000_0000, 0, 0);
    wait_idle();
    m_seq = m_seq + 1;
    peer_seg(FLAG_ACK, m_rem, m_seq, 0);
    wait_conn(1'b1);
    m_ack = m_ack + 1;
    expect_seg(K_ACK, m_seq, m_ack, 0);
    expect_seg(K_FIN, m_seq, m_ack, 0);
    peer_seg(FLAG_FIN | FLAG_ACK, m_rem, m_seq, 0);
    wait_idle();
    listen <= 1'b0;
    peer_seg(FLAG_ACK, m_rem + 1, m_seq + 1, 0);
    wait_conn(1'b0);
    end_test();

    active_open(32'h4000_0000, 32'h5000_0000);
    cur_test = "reset_timeout";
    expect_seg(K_RST, m_seq, m_ack, 0);
    peer_seg(FLAG_RST | FLAG_ACK, m_rem, m_seq, 0);
    connect <= 1'b0;  // engine already left idle
    wait_idle();
    wait_conn(1'b0);
    // without a syn-ack the timer closes and the syn repeats
    expect_seg(K_SYN, 32'h6000_0000, 0, 0);
    expect_seg(K_SYN, 32'h6000_0000, 0, 0);
    isn <= 32'h6000_0000;
    connect <= 1'b1;
    wait_idle();
    connect <= 1'b0;
    end_test();

    assert (exp_q.size() == 0) else begin
      $display("%0d expected segments were never sent", exp_q.size());
      errors++;
    end
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
logic/tcp_pkg.sv
logic/tcp_rx_filter.sv
logic/tcp_conn_timer.sv
logic/tcp_conn_fsm.sv
logic/tcp_engine.sv
sim/tcp_engine_checker.sv
sim/tcp_engine_tb.sv
